//--- build.f
+incdir+.
debug_pkg.sv
asyncFifo.sv
serialLink.sv
cmdEngine.sv
debugTop.sv
debugTop_assert.sv
debugChecker.sv
tb_debugTop.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -f build.f --top-module tb_debugTop -o Vtb_debugTop
	./obj_dir/Vtb_debugTop +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "Test failed"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "Run ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- tb_debugTop.sv
`timescale 1ns/1ps
`include "debug_params.svh"

module tb_debugTop;
    localparam int NUM_CMDS = 3 + 32 + 4 + 6 + 30;
    // About 60 debug cycles per command at 2.5 clk cycles each
    localparam int MAX_CYCLES = NUM_CMDS * 60 * 5 / 2;

    logic       clk;
    logic       rst;
    logic       debugClk;
    logic       debugCs;
    logic       debugDi;
    logic       debugDo;
    logic [3:0] led;
    logic [3:0] testId;
    int         pairsDone;
    int         errorCount;
    int         expectedPairs = 0;
    int         cycleCount = 0;

    always #4 clk = ~clk;
    always #10 debugClk = ~debugClk;

    debugTop debugTop_inst (
        .clk      (clk),
        .rst      (rst),
        .debugClk (debugClk),
        .debugCs  (debugCs),
        .debugDi  (debugDi),
        .debugDo  (debugDo),
        .led      (led)
    );

    debugChecker replyCheck (
        .debugClk   (debugClk),
        .debugCs    (debugCs),
        .debugDi    (debugDi),
        .debugDo    (debugDo),
        .led        (led),
        .testId     (testId),
        .pairsDone  (pairsDone),
        .errorCount (errorCount)
    );

    bind debugTop debugTop_assert assertInst (
        .clk       (clk),
        .rst       (rst),
        .debugClk  (debugClk),
        .linkRst   (linkRst),
        .inRdEn    (inRdEn),
        .inRdData  (inRdData),
        .outWrEn   (outWrEn),
        .outWrData (outWrData),
        .outFull   (outFull),
        .led       (led),
        .debugDo   (debugDo)
    );

    // Shifts one command out MSB first at one bit per debug clock
    task automatic sendByte(input logic [7:0] cmd);
        for (int i = 7; i >= 0; i--) begin
            @(posedge debugClk);
            #1 debugDi = cmd[i];
        end
    endtask

    // Keep clocking zeros until the checker has seen enough reply pairs
    task automatic waitReplies(input int target);
        while (pairsDone < target) begin
            @(posedge debugClk);
            #1 debugDi = 1'b0;
        end
    endtask

    task automatic runCommand(input logic [7:0] cmd);
        sendByte(cmd);
        expectedPairs++;
        waitReplies(expectedPairs);
    endtask

    function automatic logic [7:0] unknownCmd();
        logic [7:0] cmd;
        cmd = 8'h80 | 8'($urandom);
        while (cmd == `DEBUG_CMD_LED_OFF || cmd == `DEBUG_CMD_LED_ON ||
               cmd == `DEBUG_CMD_LED_READ || cmd[7:4] == `DEBUG_CMD_LED_SET_HI) begin
            cmd = 8'h80 | 8'($urandom);
        end
        return cmd;
    endfunction

    function automatic logic [7:0] randomCmd();
        case ($urandom % 5)
            0:       return `DEBUG_CMD_LED_OFF;
            1:       return `DEBUG_CMD_LED_ON;
            2:       return {`DEBUG_CMD_LED_SET_HI, 4'($urandom)};
            3:       return `DEBUG_CMD_LED_READ;
            default: return unknownCmd();
        endcase
    endfunction

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Timeout: replies still missing after %0d clk cycles", cycleCount);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h0e8b_7b9f));
        clk      = 1'b0;
        debugClk = 1'b0;
        rst      = 1'b1;
        debugCs  = 1'b0;
        debugDi  = 1'b0;
        testId   = 4'd0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        // Debug-side reset goes through a two-flop synchronizer
        repeat (4) @(posedge debugClk);
        #1 debugCs = 1'b1;

        testId = 4'd1;
        repeat (20) @(posedge debugClk);
        #1 testId = 4'd2;

        runCommand({`DEBUG_CMD_LED_SET_HI, 4'hA});
        runCommand(`DEBUG_CMD_LED_ON);
        runCommand(`DEBUG_CMD_LED_OFF);

        testId = 4'd3;
        for (int n = 0; n < 16; n++) begin
            runCommand({`DEBUG_CMD_LED_SET_HI, 4'(n)});
            runCommand(`DEBUG_CMD_LED_READ);
        end

        testId = 4'd4;
        repeat (4) runCommand(unknownCmd());

        testId = 4'd5;
        repeat (6) sendByte(randomCmd());
        expectedPairs += 6;
        waitReplies(expectedPairs);

        testId = 4'd6;
        repeat (30) runCommand(randomCmd());

        // Room for a stray reply to show up
        repeat (30) @(posedge debugClk);
        #1;
        $display("Replies: %0d, checker errors: %0d, assertion failures: %0d",
                 pairsDone, errorCount, debugTop_inst.assertInst.failCount);
        if (errorCount == 0 && debugTop_inst.assertInst.failCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- debugChecker.sv
`timescale 1ns/1ps
`include "debug_params.svh"

module debugChecker import debug_pkg::*; (
    input  logic       debugClk,
    input  logic       debugCs,
    input  logic       debugDi,
    input  logic       debugDo,
    input  logic [3:0] led,
    input  logic [3:0] testId,
    output int         pairsDone,
    output int         errorCount
);
    respByte_t  cmdQueue[$];
    respByte_t  cmdShift  = '0;
    respByte_t  rxShift   = '0;
    respByte_t  firstByte = '0;
    logic       inByte    = 1'b0;
    logic       haveFirst = 1'b0;
    int         bitsLeft  = 0;
    logic [3:0] modelLed  = 4'h0;

    initial begin
        pairsDone  = 0;
        errorCount = 0;
    end

    function automatic string testName(input logic [3:0] id);
        case (id)
            4'd1:    return "resetIdle";
            4'd2:    return "ledOnOff";
            4'd3:    return "ledSetRead";
            4'd4:    return "unknownCmd";
            4'd5:    return "burst";
            4'd6:    return "randomMix";
            default: return "setup";
        endcase
    endfunction

    // Returns {status, new led} for one command applied to ledIn
    function automatic logic [11:0] refModel(input respByte_t cmd, input logic [3:0] ledIn);
        logic [7:0] status;
        logic [3:0] ledOut;
        status = 8'h00;
        ledOut = ledIn;
        if (cmd == `DEBUG_CMD_LED_OFF) begin
            ledOut[0] = 1'b0;
            status    = 8'h01;
        end else if (cmd == `DEBUG_CMD_LED_ON) begin
            ledOut[0] = 1'b1;
            status    = 8'h01;
        end else if (cmd[7:4] == `DEBUG_CMD_LED_SET_HI) begin
            ledOut = cmd[3:0];
            status = 8'h01;
        end else if (cmd == `DEBUG_CMD_LED_READ) begin
            status = {4'h0, ledIn};
        end
        return {status, ledOut};
    endfunction

    task automatic checkPair(input respByte_t echo, input respByte_t status);
        respByte_t   cmd;
        logic [11:0] want;
        if (cmdQueue.size() == 0) begin
            errorCount++;
            $display("%s: reply %02h %02h arrived with no command pending",
                     testName(testId), echo, status);
        end else begin
            cmd      = cmdQueue.pop_front();
            want     = refModel(cmd, modelLed);
            modelLed = want[3:0];
            if (echo !== cmd) begin
                errorCount++;
                $display("Error %s: command echo expected %02h actual %02h",
                         testName(testId), cmd, echo);
            end
            if (status !== want[11:4]) begin
                errorCount++;
                $display("Error %s: status for %02h expected %02h actual %02h",
                         testName(testId), cmd, want[11:4], status);
            end
            // Later commands in flight may already have moved the LEDs
            if (cmdQueue.size() == 0 && led !== modelLed) begin
                errorCount++;
                $display("Error %s: led after %02h expected %h actual %h",
                         testName(testId), cmd, modelLed, led);
            end
        end
        pairsDone++;
    endtask

    always @(posedge debugClk) begin
        if (debugCs) begin
            // Commands on debugDi, idle zeros skipped
            if (cmdShift[7]) begin
                cmdShift = {7'b0, debugDi};
            end else begin
                cmdShift = {cmdShift[6:0], debugDi};
            end
            if (cmdShift[7]) begin
                cmdQueue.push_back(cmdShift);
            end
            // Replies on debugDo, a start bit then 8 data bits
            if (inByte) begin
                rxShift = {rxShift[6:0], debugDo};
                bitsLeft--;
                if (bitsLeft == 0) begin
                    inByte = 1'b0;
                    if (haveFirst) begin
                        checkPair(firstByte, rxShift);
                    end else begin
                        firstByte = rxShift;
                    end
                    haveFirst = !haveFirst;
                end
            end else if (debugDo === 1'b1) begin
                inByte   = 1'b1;
                bitsLeft = 8;
            end else if (debugDo !== 1'b0) begin
                errorCount++;
                $display("%s: debugDo is unknown between replies", testName(testId));
            end
            if (testId == 4'd1 && (led !== 4'h0 || debugDo !== 1'b0)) begin
                errorCount++;
                $display("Error %s: led/debugDo expected 0/0 actual %h/%b",
                         testName(testId), led, debugDo);
            end
        end
    end

endmodule

//--- debugTop_assert.sv
`timescale 1ns/1ps

module debugTop_assert (
    input logic       clk,
    input logic       rst,
    input logic       debugClk,
    input logic       linkRst,
    input logic       inRdEn,
    input logic [7:0] inRdData,
    input logic       outWrEn,
    input logic [7:0] outWrData,
    input logic       outFull,
    input logic [3:0] led,
    input logic       debugDo
);
    // Number of assertion failures so far
    int unsigned failCount = 0;

    // Every pop takes a written command byte, so its top bit is set
    assert property (@(posedge clk) disable iff (rst) inRdEn |-> inRdData[7])
        else begin
            failCount++;
            $error("inbound FIFO popped an entry that holds no command");
        end

    // Status byte follows the echo on the next cycle unless the outbound FIFO fills up
    assert property (@(posedge clk) disable iff (rst)
                     (outWrEn && outWrData[7]) |=> (outFull || (outWrEn && !outWrData[7])))
        else begin
            failCount++;
            $error("status byte did not follow the command echo");
        end

    assert property (@(posedge clk) rst |=> (led == 4'h0))
        else begin
            failCount++;
            $error("led not cleared by reset");
        end

    // Serial output is low once the debug-side reset has been applied
    assert property (@(posedge debugClk) linkRst |=> !debugDo)
        else begin
            failCount++;
            $error("debugDo not low after debug-side reset");
        end

endmodule

//--- debugTop.sv
`timescale 1ns/1ps
`include "debug_params.svh"

module debugTop import debug_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       debugClk,
    input  logic       debugCs,
    input  logic       debugDi,
    output logic       debugDo,
    output logic [3:0] led
);
    logic      linkRst;

    // Inbound path, debug domain to system clock
    logic      inWrEn;
    cmdFrame_t inWrData;
    logic      inFull;
    logic      inRdEn;
    cmdFrame_t inRdData;
    logic      inEmpty;

    // Outbound path, system clock to debug domain
    logic      outWrEn;
    respByte_t outWrData;
    logic      outFull;
    logic      outRdEn;
    respByte_t outRdData;
    logic      outEmpty;

    serialLink link (
        .clk       (clk),
        .rst       (rst),
        .debugClk  (debugClk),
        .debugCs   (debugCs),
        .debugDi   (debugDi),
        .debugDo   (debugDo),
        .inWrEn    (inWrEn),
        .inWrData  (inWrData),
        .outRdEn   (outRdEn),
        .outRdData (outRdData),
        .outEmpty  (outEmpty),
        .linkRst   (linkRst)
    );

    // A full inbound FIFO drops the byte
    asyncFifo #(
        .payload_t (cmdFrame_t),
        .DEPTH     (`DEBUG_IN_DEPTH)
    ) inFifo (
        .wrClk  (debugClk),
        .wrRst  (linkRst),
        .wrEn   (inWrEn),
        .wrData (inWrData),
        .full   (inFull),
        .rdClk  (clk),
        .rdRst  (rst),
        .rdEn   (inRdEn),
        .rdData (inRdData),
        .empty  (inEmpty)
    );

    asyncFifo #(
        .payload_t (respByte_t),
        .DEPTH     (`DEBUG_OUT_DEPTH)
    ) outFifo (
        .wrClk  (clk),
        .wrRst  (rst),
        .wrEn   (outWrEn),
        .wrData (outWrData),
        .full   (outFull),
        .rdClk  (debugClk),
        .rdRst  (linkRst),
        .rdEn   (outRdEn),
        .rdData (outRdData),
        .empty  (outEmpty)
    );

    cmdEngine engine (
        .clk        (clk),
        .rst        (rst),
        .cmdData    (inRdData),
        .cmdEmpty   (inEmpty),
        .cmdRdEn    (inRdEn),
        .respWrEn   (outWrEn),
        .respWrData (outWrData),
        .respFull   (outFull),
        .led        (led)
    );

endmodule

//--- cmdEngine.sv
`timescale 1ns/1ps
`include "debug_params.svh"

module cmdEngine import debug_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cmdFrame_t  cmdData,
    input  logic       cmdEmpty,
    output logic       cmdRdEn,
    output logic       respWrEn,
    output respByte_t  respWrData,
    input  logic       respFull,
    output logic [3:0] led
);
    engState_t  state;
    cmdFrame_t  frame;
    respByte_t  cmdByte;
    respByte_t  status;
    respByte_t  statusNext;
    logic [3:0] ledNext;

    assign cmdByte = respByte_t'(frame);

    // Strobes come straight from the state, writes wait out a full FIFO
    assign cmdRdEn    = (state == EngIdle) && !cmdEmpty;
    assign respWrEn   = ((state == EngSendCmd) || (state == EngSendStatus)) && !respFull;
    assign respWrData = (state == EngSendStatus) ? status : cmdByte;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= EngIdle;
        end else begin
            case (state)
                EngIdle: begin
                    if (cmdRdEn) begin
                        state <= EngExecute;
                    end
                end
                EngExecute: begin
                    state <= EngSendCmd;
                end
                EngSendCmd: begin
                    if (!respFull) begin
                        state <= EngSendStatus;
                    end
                end
                EngSendStatus: begin
                    if (!respFull) begin
                        state <= EngIdle;
                    end
                end
                default: begin
                    state <= EngIdle;
                end
            endcase
        end
    end

    // Frame captured on the pop
    always_ff @(posedge clk) begin
        if (cmdRdEn) begin
            frame <= cmdData;
        end
    end

    // Command decode, LED rule and status byte
    always_comb begin
        ledNext    = led;
        statusNext = `DEBUG_STATUS_BAD;
        if (cmdByte == `DEBUG_CMD_LED_OFF) begin
            ledNext[0] = 1'b0;
            statusNext = `DEBUG_STATUS_OK;
        end else if (cmdByte == `DEBUG_CMD_LED_ON) begin
            ledNext[0] = 1'b1;
            statusNext = `DEBUG_STATUS_OK;
        end else if (frame.opcode == `DEBUG_CMD_LED_SET_HI) begin
            ledNext    = frame.arg;
            statusNext = `DEBUG_STATUS_OK;
        end else if (cmdByte == `DEBUG_CMD_LED_READ) begin
            statusNext = {4'h0, led};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            led <= '0;
        end else if (state == EngExecute) begin
            led <= ledNext;
        end
    end

    always_ff @(posedge clk) begin
        if (state == EngExecute) begin
            status <= statusNext;
        end
    end

endmodule

//--- serialLink.sv
`timescale 1ns/1ps
`include "debug_params.svh"

module serialLink import debug_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      debugClk,
    input  logic      debugCs,
    input  logic      debugDi,
    output logic      debugDo,
    output logic      inWrEn,
    output cmdFrame_t inWrData,
    output logic      outRdEn,
    input  respByte_t outRdData,
    input  logic      outEmpty,
    output logic      linkRst
);
    localparam int W = `DEBUG_BYTE_W;

    logic         rstReg;
    logic         rstSync1;
    logic         rstSync2;
    logic [W-1:0] inShift;
    logic [W:0]   outShift;
    logic [2:0]   bitCnt;
    logic         busy;

    // Registered copy of rst so the crossing starts from a flop
    always_ff @(posedge clk) begin
        rstReg <= rst;
    end

    // Two-flop synchronizer into the debug domain
    always_ff @(posedge debugClk) begin
        rstSync1 <= rstReg;
        rstSync2 <= rstSync1;
    end

    assign linkRst = rstSync2;

    // Inbound bytes
    // A byte is complete once its leading 1 sits in the top bit
    assign inWrEn   = debugCs && inShift[W-1];
    assign inWrData = cmdFrame_t'(inShift);

    always_ff @(posedge debugClk) begin
        if (linkRst) begin
            inShift <= '0;
        end else if (debugCs) begin
            if (inShift[W-1]) begin
                // Byte handed to the FIFO this edge, start the next one
                inShift <= {{(W-1){1'b0}}, debugDi};
            end else begin
                inShift <= {inShift[W-2:0], debugDi};
            end
        end
    end

    // Outbound bytes
    // Pop as soon as the previous byte has put its last data bit on the pin
    assign outRdEn = debugCs && !busy && !outEmpty;
    assign debugDo = outShift[W];

    always_ff @(posedge debugClk) begin
        if (linkRst) begin
            outShift <= '0;
            bitCnt   <= '0;
            busy     <= 1'b0;
        end else if (debugCs) begin
            if (outRdEn) begin
                // Start bit in front of the data, MSB first
                outShift <= {1'b1, outRdData};
                bitCnt   <= '0;
                busy     <= 1'b1;
            end else begin
                // Shifting in zeros keeps the line low between bytes
                outShift <= {outShift[W-1:0], 1'b0};
                if (busy) begin
                    bitCnt <= bitCnt + 3'd1;
                    if (bitCnt == 3'd7) begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

//--- asyncFifo.sv
`timescale 1ns/1ps

module asyncFifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    // Write side
    input  logic     wrClk,
    input  logic     wrRst,
    input  logic     wrEn,
    input  payload_t wrData,
    output logic     full,
    // Read side
    input  logic     rdClk,
    input  logic     rdRst,
    input  logic     rdEn,
    output payload_t rdData,
    output logic     empty
);
    // Pointers carry one extra wrap bit; DEPTH of at least 4 is assumed
    localparam int AW = $clog2(DEPTH);

    payload_t mem [DEPTH];

    logic [AW:0] wrBin;
    logic [AW:0] wrGray;
    logic [AW:0] wrBinNext;
    logic [AW:0] rdBin;
    logic [AW:0] rdGray;
    logic [AW:0] rdBinNext;
    logic [AW:0] rdGraySync1;
    logic [AW:0] rdGraySync2;
    logic [AW:0] wrGraySync1;
    logic [AW:0] wrGraySync2;
    logic        wrAccept;
    logic        rdAccept;

    function automatic logic [AW:0] bin2gray(input logic [AW:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    assign wrAccept  = wrEn && !full;
    assign rdAccept  = rdEn && !empty;
    assign wrBinNext = wrBin + (AW+1)'(1);
    assign rdBinNext = rdBin + (AW+1)'(1);

    // Write domain
    always_ff @(posedge wrClk) begin
        if (wrAccept) begin
            mem[wrBin[AW-1:0]] <= wrData;
        end
    end

    always_ff @(posedge wrClk) begin
        if (wrRst) begin
            wrBin       <= '0;
            wrGray      <= '0;
            rdGraySync1 <= '0;
            rdGraySync2 <= '0;
        end else begin
            if (wrAccept) begin
                wrBin  <= wrBinNext;
                wrGray <= bin2gray(wrBinNext);
            end
            rdGraySync1 <= rdGray;
            rdGraySync2 <= rdGraySync1;
        end
    end

    // Full when the write pointer is one lap ahead of the read pointer
    assign full = (wrGray == {~rdGraySync2[AW:AW-1], rdGraySync2[AW-2:0]});

    // Read domain
    always_ff @(posedge rdClk) begin
        if (rdRst) begin
            rdBin       <= '0;
            rdGray      <= '0;
            wrGraySync1 <= '0;
            wrGraySync2 <= '0;
        end else begin
            if (rdAccept) begin
                rdBin  <= rdBinNext;
                rdGray <= bin2gray(rdBinNext);
            end
            wrGraySync1 <= wrGray;
            wrGraySync2 <= wrGraySync1;
        end
    end

    assign empty = (rdGray == wrGraySync2);

    // First-word fall-through, head entry is visible while not empty
    assign rdData = mem[rdBin[AW-1:0]];

endmodule

//--- debug_pkg.sv
`include "debug_params.svh"

package debug_pkg;

    // One received command byte, upper nibble first on the wire
    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] arg;
    } cmdFrame_t;

    // One reply byte, command echo or status
    typedef logic [`DEBUG_BYTE_W-1:0] respByte_t;

    // Command engine states
    typedef enum logic [1:0] {
        EngIdle,
        EngExecute,
        EngSendCmd,
        EngSendStatus
    } engState_t;

endpackage

//--- debug_params.svh
`ifndef DEBUG_PARAMS_SVH
`define DEBUG_PARAMS_SVH

// FIFO depths, both must be powers of two
`define DEBUG_IN_DEPTH  8
`define DEBUG_OUT_DEPTH 16

// Width of one serial byte
`define DEBUG_BYTE_W 8

// Command opcodes
`define DEBUG_CMD_LED_OFF    8'h80
`define DEBUG_CMD_LED_ON     8'h81
`define DEBUG_CMD_LED_READ   8'hA0
`define DEBUG_CMD_LED_SET_HI 4'h9

// Reply status codes
`define DEBUG_STATUS_OK  8'h01
`define DEBUG_STATUS_BAD 8'h00

`endif
